//--- rtl/dvbs2_ts_pkg.sv
`default_nettype none

package dvbs2_ts_pkg;

	// one transport-stream byte
	typedef logic [7:0] ts_data_t;

	// byte index inside a packet
	typedef logic [7:0] ts_count_t;

	// framed byte as written into the FIFO
	typedef struct packed {
		ts_data_t data;
		logic     sop;
	} ts_byte_t;

	localparam int TS_PACKET_LEN = 188;
	localparam ts_data_t TS_SYNC_BYTE = 8'h47;

	// byte FIFO sizing
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

	// address plus wrap bit
	typedef logic [FIFO_ADDR_W:0] fifo_ptr_t;

endpackage

`default_nettype wire

//--- rtl/dvbs2_sym_pkg.sv
`default_nettype none

package dvbs2_sym_pkg;

	// one signed axis value
	typedef logic signed [15:0] sym_level_t;

	typedef struct packed {
		sym_level_t re;
		sym_level_t im;
	} qpsk_sym_t;

	// +/- 1/sqrt(2) in the output fixed-point format
	localparam sym_level_t QPSK_POS = 16'h0b50;
	localparam sym_level_t QPSK_NEG = 16'hf4b0;

	localparam int SYMS_PER_BYTE = 4;

	typedef enum logic {
		MAP_IDLE,
		MAP_EMIT
	} mapper_state_t;

endpackage

`default_nettype wire

//--- rtl/ts_packet_framer.sv
`timescale 1ns/1ps
`default_nettype none

module ts_packet_framer (
	input  wire logic                  mpeg_clk,
	input  wire logic                  rst_n,
	input  wire logic                  mpeg_valid,
	input  wire logic                  mpeg_sync,
	input  wire dvbs2_ts_pkg::ts_data_t mpeg_data,
	output logic                       wr_en,
	output dvbs2_ts_pkg::ts_byte_t     wr_byte,
	output logic                       sync_error
);

	import dvbs2_ts_pkg::*;

	typedef enum logic {
		FR_HUNT,
		FR_LOCKED
	} framer_state_t;

	framer_state_t state;
	// index of the next expected byte in the packet
	ts_count_t     count;
	logic          is_sync;
	logic          last_byte;

	// source flag and byte value must both agree
	assign is_sync = mpeg_sync && (mpeg_data == TS_SYNC_BYTE);
	assign last_byte = (count == ts_count_t'(TS_PACKET_LEN - 1));

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			state <= FR_HUNT;
			count <= '0;
			wr_en <= 1'b0;
			sync_error <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			sync_error <= 1'b0;
			if (mpeg_valid) begin
				case (state)
					FR_HUNT: begin
						// discard until a proper sync byte shows up
						if (is_sync) begin
							state <= FR_LOCKED;
							wr_en <= 1'b1;
							count <= ts_count_t'(1);
						end
					end
					FR_LOCKED: begin
						if (count == '0) begin
							if (is_sync) begin
								wr_en <= 1'b1;
								count <= ts_count_t'(1);
							end else begin
								// expected a sync here, lock is lost
								state <= FR_HUNT;
								sync_error <= 1'b1;
							end
						end else if (is_sync) begin
							// early sync cuts the current packet short
							wr_en <= 1'b1;
							count <= ts_count_t'(1);
							sync_error <= 1'b1;
						end else begin
							wr_en <= 1'b1;
							count <= last_byte ? '0 : count + 1'b1;
						end
					end
					default: begin
						state <= FR_HUNT;
					end
				endcase
			end
		end
	end

	// payload follows the input one cycle later
	// every forwarded byte that is a sync byte starts a packet
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid) begin
			wr_byte.data <= mpeg_data;
			wr_byte.sop <= is_sync;
		end
	end

endmodule

`default_nettype wire

//--- rtl/ts_byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ts_byte_fifo (
	input  wire logic                  mpeg_clk,
	input  wire logic                  rst_n,
	input  wire logic                  wr_en,
	input  wire dvbs2_ts_pkg::ts_byte_t wr_byte,
	input  wire logic                  rd_en,
	output dvbs2_ts_pkg::ts_byte_t     rd_byte,
	output logic                       empty,
	output logic                       overflow
);

	import dvbs2_ts_pkg::*;

	ts_byte_t  mem [FIFO_DEPTH];
	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	logic      full;
	logic      do_wr;
	logic      do_rd;

	assign empty = (wr_ptr == rd_ptr);
	// same address, opposite wrap bit
	assign full = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
		(wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// show-ahead head entry
	assign rd_byte = mem[rd_ptr[FIFO_ADDR_W-1:0]];

	always_ff @(posedge mpeg_clk) begin
		if (do_wr) begin
			mem[wr_ptr[FIFO_ADDR_W-1:0]] <= wr_byte;
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + fifo_ptr_t'(1);
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + fifo_ptr_t'(1);
			end
			// sticky until reset, byte is lost
			if (wr_en && full) begin
				overflow <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/qpsk_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module qpsk_mapper (
	input  wire logic                  mpeg_clk,
	input  wire logic                  rst_n,
	input  wire logic                  empty,
	input  wire dvbs2_ts_pkg::ts_byte_t rd_byte,
	output logic                       rd_en,
	output logic                       symbol_oe,
	output dvbs2_sym_pkg::qpsk_sym_t   symbol,
	output logic                       symbol_sop
);

	import dvbs2_ts_pkg::*;
	import dvbs2_sym_pkg::*;

	localparam int PAIR_W = $clog2(SYMS_PER_BYTE);

	mapper_state_t     state;
	ts_data_t          shift_reg;
	logic              sop_pend;
	logic [PAIR_W-1:0] pair_cnt;
	logic              last_pair;

	assign last_pair = (pair_cnt == PAIR_W'(SYMS_PER_BYTE - 1));

	// pop when idle or while the last symbol of a byte goes out
	assign rd_en = !empty && ((state == MAP_IDLE) || last_pair);

	// msb pair first, 0 -> positive, 1 -> negative
	assign symbol_oe = (state == MAP_EMIT);
	assign symbol.re = shift_reg[7] ? QPSK_NEG : QPSK_POS;
	assign symbol.im = shift_reg[6] ? QPSK_NEG : QPSK_POS;
	assign symbol_sop = symbol_oe && sop_pend && (pair_cnt == '0);

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			state <= MAP_IDLE;
			pair_cnt <= '0;
		end else begin
			if (rd_en) begin
				state <= MAP_EMIT;
				pair_cnt <= '0;
			end else if (state == MAP_EMIT) begin
				if (last_pair) begin
					// nothing buffered, wait for the next byte
					state <= MAP_IDLE;
					pair_cnt <= '0;
				end else begin
					pair_cnt <= pair_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (rd_en) begin
			shift_reg <= rd_byte.data;
			sop_pend <= rd_byte.sop;
		end else if (state == MAP_EMIT) begin
			shift_reg <= {shift_reg[5:0], 2'b00};
		end
	end

endmodule

`default_nettype wire

//--- rtl/dvbs2_ts_mapper_top.sv
`timescale 1ns/1ps
`default_nettype none

module dvbs2_ts_mapper_top (
	input  wire logic                  mpeg_clk,
	input  wire logic                  rst_n,
	input  wire logic                  mpeg_valid,
	input  wire logic                  mpeg_sync,
	input  wire dvbs2_ts_pkg::ts_data_t mpeg_data,
	output logic                       symbol_oe,
	output dvbs2_sym_pkg::qpsk_sym_t   symbol,
	output logic                       symbol_sop,
	output logic                       sync_error,
	output logic                       fifo_overflow
);

	import dvbs2_ts_pkg::*;

	// framer to FIFO
	logic     wr_en;
	ts_byte_t wr_byte;

	// FIFO to mapper
	logic     empty;
	logic     rd_en;
	ts_byte_t rd_byte;

	ts_packet_framer framer_inst (
		.mpeg_clk   (mpeg_clk),
		.rst_n      (rst_n),
		.mpeg_valid (mpeg_valid),
		.mpeg_sync  (mpeg_sync),
		.mpeg_data  (mpeg_data),
		.wr_en      (wr_en),
		.wr_byte    (wr_byte),
		.sync_error (sync_error)
	);

	ts_byte_fifo fifo_inst (
		.mpeg_clk (mpeg_clk),
		.rst_n    (rst_n),
		.wr_en    (wr_en),
		.wr_byte  (wr_byte),
		.rd_en    (rd_en),
		.rd_byte  (rd_byte),
		.empty    (empty),
		.overflow (fifo_overflow)
	);

	qpsk_mapper mapper_inst (
		.mpeg_clk   (mpeg_clk),
		.rst_n      (rst_n),
		.empty      (empty),
		.rd_byte    (rd_byte),
		.rd_en      (rd_en),
		.symbol_oe  (symbol_oe),
		.symbol     (symbol),
		.symbol_sop (symbol_sop)
	);

endmodule

`default_nettype wire

//--- verif/dvbs2_ts_mapper_checker.sv
`timescale 1ns/1ps
`default_nettype none

module dvbs2_ts_mapper_checker (
	input wire logic                    mpeg_clk,
	input wire logic                    rst_n,
	input wire logic                    symbol_oe,
	input wire dvbs2_sym_pkg::qpsk_sym_t symbol,
	input wire logic                    symbol_sop,
	input wire logic                    sync_error,
	input wire logic                    fifo_overflow
);

	import dvbs2_sym_pkg::*;

	sop_with_oe: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		symbol_sop |-> symbol_oe)
		else $error("symbol_sop raised without symbol_oe");

	// only the two constellation levels on either axis
	levels_valid: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		symbol_oe |-> ((symbol.re == QPSK_POS || symbol.re == QPSK_NEG) &&
			(symbol.im == QPSK_POS || symbol.im == QPSK_NEG)))
		else $error("symbol axis outside the QPSK levels");

	overflow_sticky: assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		!$fell(fifo_overflow))
		else $error("fifo_overflow fell outside reset");

	quiet_after_reset: assert property (@(posedge mpeg_clk)
		$rose(rst_n) |-> (!symbol_oe && !symbol_sop && !sync_error && !fifo_overflow))
		else $error("outputs not low after reset");

endmodule

bind dvbs2_ts_mapper_top dvbs2_ts_mapper_checker checker_inst (.*);

`default_nettype wire

//--- verif/tb_dvbs2_ts_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dvbs2_ts_mapper;

	import dvbs2_ts_pkg::*;
	import dvbs2_sym_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int GAP = 4;
	localparam int TOTAL_BYTES = 5 + 100 + 7 * TS_PACKET_LEN;
	localparam int MARGIN_NS = 2000;

	logic      mpeg_clk = 1'b0;
	logic      rst_n;
	logic      mpeg_valid;
	logic      mpeg_sync;
	ts_data_t  mpeg_data;
	logic      symbol_oe;
	qpsk_sym_t symbol;
	logic      symbol_sop;
	logic      sync_error;
	logic      fifo_overflow;

	logic [31:0] lfsr_state = 32'hb07a_87ad;

	// reference model state
	qpsk_sym_t exp_sym_q[$];
	logic      exp_sop_q[$];
	logic      fr_locked;
	int        fr_cnt;
	logic      wr_pend;
	ts_data_t  wr_data_pend;
	logic      wr_sop_pend;
	logic      exp_err;
	logic      exp_ovf;
	int        occ;
	logic      map_busy;
	int        map_pair;

	dvbs2_ts_mapper_top dvbs2_ts_mapper_top_inst (
		.mpeg_clk      (mpeg_clk),
		.rst_n         (rst_n),
		.mpeg_valid    (mpeg_valid),
		.mpeg_sync     (mpeg_sync),
		.mpeg_data     (mpeg_data),
		.symbol_oe     (symbol_oe),
		.symbol        (symbol),
		.symbol_sop    (symbol_sop),
		.sync_error    (sync_error),
		.fifo_overflow (fifo_overflow)
	);

	always #(CLK_PERIOD / 2) mpeg_clk = ~mpeg_clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic compare_symbol(input string name, input qpsk_sym_t act, input qpsk_sym_t exp);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
		end
	endtask

	task automatic compare_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			fail_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
		end
	endtask

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return out;
	endfunction

	function automatic ts_data_t random_byte();
		ts_data_t b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], lfsr_bit()};
		end
		return b;
	endfunction

	// msb pair first, first bit of a pair on re, a 1 bit is negative
	function automatic void push_byte(input ts_data_t data, input logic sop);
		qpsk_sym_t sym;
		for (int k = 0; k < SYMS_PER_BYTE; k++) begin
			sym.re = data[7 - 2 * k] ? QPSK_NEG : QPSK_POS;
			sym.im = data[6 - 2 * k] ? QPSK_NEG : QPSK_POS;
			exp_sym_q.push_back(sym);
			exp_sop_q.push_back(sop && (k == 0));
		end
	endfunction

	// outputs of this cycle first, then the model steps to the next edge
	always @(negedge mpeg_clk) begin
		if (!rst_n) begin
			fr_locked = 1'b0;
			fr_cnt = 0;
			wr_pend = 1'b0;
			exp_err = 1'b0;
			exp_ovf = 1'b0;
			occ = 0;
			map_busy = 1'b0;
			map_pair = 0;
		end else begin
			compare_bit("sync_error", sync_error, exp_err);
			compare_bit("fifo_overflow", fifo_overflow, exp_ovf);
			if (symbol_oe) begin
				if (exp_sym_q.size() == 0) begin
					fail_run("symbol came out while no symbol was expected");
				end else begin
					compare_symbol("symbol", symbol, exp_sym_q.pop_front());
					compare_bit("symbol_sop", symbol_sop, exp_sop_q.pop_front());
				end
			end
			step_model();
		end
	end

	task automatic step_model();
		logic rd;
		logic is_sync;
		// FIFO and mapper pop when idle or on the fourth symbol
		rd = (occ > 0) && (!map_busy || map_pair == SYMS_PER_BYTE - 1);
		if (wr_pend && occ == FIFO_DEPTH) begin
			exp_ovf = 1'b1;
		end else if (wr_pend) begin
			occ++;
			push_byte(wr_data_pend, wr_sop_pend);
		end
		if (rd) begin
			occ--;
			map_busy = 1'b1;
			map_pair = 0;
		end else if (map_busy) begin
			if (map_pair == SYMS_PER_BYTE - 1) begin
				map_busy = 1'b0;
			end else begin
				map_pair++;
			end
		end
		// framer
		is_sync = mpeg_sync && (mpeg_data == TS_SYNC_BYTE);
		wr_pend = 1'b0;
		exp_err = 1'b0;
		wr_data_pend = mpeg_data;
		wr_sop_pend = is_sync;
		if (mpeg_valid) begin
			if (!fr_locked) begin
				if (is_sync) begin
					fr_locked = 1'b1;
					wr_pend = 1'b1;
					fr_cnt = 1;
				end
			end else if (fr_cnt == 0 && !is_sync) begin
				fr_locked = 1'b0;
				exp_err = 1'b1;
			end else begin
				wr_pend = 1'b1;
				exp_err = is_sync && (fr_cnt != 0);
				fr_cnt = is_sync ? 1 : ((fr_cnt == TS_PACKET_LEN - 1) ? 0 : fr_cnt + 1);
			end
		end
	endtask

	// gap counts cycles from one byte to the next
	task automatic send_byte(input ts_data_t data, input logic sync, input int gap);
		@(posedge mpeg_clk);
		#1;
		mpeg_valid = 1'b1;
		mpeg_sync = sync;
		mpeg_data = data;
		for (int i = 1; i < gap; i++) begin
			@(posedge mpeg_clk);
			#1;
			mpeg_valid = 1'b0;
			mpeg_sync = 1'b0;
		end
	endtask

	// bad_sync sends a flagged first byte with the wrong value
	task automatic send_packet(input int gap, input int len, input logic bad_sync);
		send_byte(bad_sync ? ~TS_SYNC_BYTE : TS_SYNC_BYTE, 1'b1, gap);
		for (int i = 1; i < len; i++) begin
			send_byte(random_byte(), 1'b0, gap);
		end
	endtask

	task automatic wait_drain();
		@(posedge mpeg_clk);
		#1;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		repeat (2) @(posedge mpeg_clk);
		while (exp_sym_q.size() != 0 || map_busy) begin
			@(posedge mpeg_clk);
		end
	endtask

	task automatic leading_bytes_ignored();
		ts_data_t b;
		for (int i = 0; i < 5; i++) begin
			b = random_byte();
			if (b == TS_SYNC_BYTE) begin
				b = 8'h46;
			end
			send_byte(b, lfsr_bit(), GAP);
		end
		send_packet(GAP, TS_PACKET_LEN, 1'b0);
		wait_drain();
	endtask

	task automatic two_locked_packets();
		send_packet(GAP, TS_PACKET_LEN, 1'b0);
		send_packet(GAP, TS_PACKET_LEN, 1'b0);
		wait_drain();
	endtask

	// next sync lands at count 100
	task automatic early_sync_restart();
		send_packet(GAP, 100, 1'b0);
		send_packet(GAP, TS_PACKET_LEN, 1'b0);
		wait_drain();
	endtask

	task automatic missing_sync_relock();
		send_packet(GAP, TS_PACKET_LEN, 1'b1);
		send_packet(GAP, TS_PACKET_LEN, 1'b0);
		wait_drain();
	endtask

	// a full packet back to back is far longer than the FIFO can absorb
	task automatic burst_overflow();
		send_packet(1, TS_PACKET_LEN, 1'b0);
		wait_drain();
		compare_bit("fifo_overflow", fifo_overflow, 1'b1);
	endtask

	initial begin
		#(TOTAL_BYTES * GAP * CLK_PERIOD + MARGIN_NS);
		fail_run("watchdog expired before the tests finished");
	end

	initial begin
		rst_n = 1'b0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		mpeg_data = '0;
		repeat (4) @(posedge mpeg_clk);
		#1;
		rst_n = 1'b1;
		leading_bytes_ignored();
		two_locked_packets();
		early_sync_restart();
		missing_sync_relock();
		burst_overflow();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
rtl/dvbs2_ts_pkg.sv
rtl/dvbs2_sym_pkg.sv
rtl/ts_packet_framer.sv
rtl/ts_byte_fifo.sv
rtl/qpsk_mapper.sv
rtl/dvbs2_ts_mapper_top.sv
verif/dvbs2_ts_mapper_checker.sv
verif/tb_dvbs2_ts_mapper.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --top-module tb_dvbs2_ts_mapper \
	-f filelist.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_dvbs2_ts_mapper > sim.log 2>&1
grep -q "Simulation failed" sim.log && { cat sim.log; exit 1; }
grep -q "Simulation passed" sim.log || { echo "no result in sim.log"; exit 1; }
cat sim.log && exit 0
